//--- common/weight_buffer_settings.svh
`ifndef WEIGHT_BUFFER_SETTINGS_SVH
`define WEIGHT_BUFFER_SETTINGS_SVH

// Input lanes, one weight bank per lane
`define WB_LANES 8

// Output channels held by every bank
`define WB_CHANNELS 8

// A 3x3 kernel is nine nibbles long
`define WB_TAPS 8'd9
`define WB_NIBBLE 4

// Kernels stored per channel and the matching address width
`define WB_DEPTH 512
`define WB_ADDR_BITS 9

`endif

//--- common/weight_buffer_pkg.sv
`include "weight_buffer_settings.svh"

package weight_buffer_pkg;

	// One 4-bit weight as it arrives on a lane
	typedef logic [`WB_NIBBLE-1:0] nibble_t;

	// A packed kernel with the first nibble received in the top bits
	typedef logic [`WB_TAPS*`WB_NIBBLE-1:0] window_t;

	// Address into one channel RAM
	typedef logic [`WB_ADDR_BITS-1:0] addr_t;

	// Selects one of the output channels
	typedef logic [$clog2(`WB_CHANNELS)-1:0] chan_idx_t;

	// Counts the nibbles of the kernel being written
	typedef logic [$clog2(`WB_TAPS)-1:0] tap_idx_t;

endpackage

//--- weight_bank/weight_ram.sv
`timescale 1ns/1ps

`include "weight_buffer_settings.svh"

module weight_ram #(
	parameter int DEPTH = `WB_DEPTH
) (
	input  logic                       clk,
	input  logic                       we,
	input  weight_buffer_pkg::addr_t   waddr,
	input  weight_buffer_pkg::addr_t   raddr,
	input  weight_buffer_pkg::window_t wdata,
	output weight_buffer_pkg::window_t rdata
);
	import weight_buffer_pkg::*;

	window_t mem [DEPTH];

	always_ff @(posedge clk) begin
		if (we) begin
			mem[waddr] <= wdata;
		end
	end

	// Data for an address shows up one clock after it is sampled
	always_ff @(posedge clk) begin
		rdata <= mem[raddr];
	end

endmodule

//--- weight_bank/weight_bank.sv
`timescale 1ns/1ps

`include "weight_buffer_settings.svh"

module weight_bank (
	input  logic                                          clk,
	input  weight_buffer_pkg::window_t                    window,
	input  logic [`WB_CHANNELS-1:0]                       chan_we,
	input  weight_buffer_pkg::addr_t [`WB_CHANNELS-1:0]   chan_addr,
	input  weight_buffer_pkg::addr_t                      read_addr,
	output weight_buffer_pkg::window_t [`WB_CHANNELS-1:0] weight_out
);

	// Every channel sees the same lane window, only its strobe decides the write
	for (genvar c = 0; c < `WB_CHANNELS; c++) begin : g_chan
		weight_ram #(
			.DEPTH(`WB_DEPTH)
		) u_ram (
			.clk  (clk),
			.we   (chan_we[c]),
			.waddr(chan_addr[c]),
			.raddr(read_addr), // Shared by all channels for a parallel read
			.wdata(window),
			.rdata(weight_out[c])
		);
	end

endmodule

//--- rtl/tap_shift_window.sv
`timescale 1ns/1ps

`include "weight_buffer_settings.svh"

module tap_shift_window (
	input  logic                                   clk,
	input  logic                                   arst_n,
	input  logic                                   write_en,
	input  weight_buffer_pkg::nibble_t [`WB_LANES-1:0] weight_in,
	output weight_buffer_pkg::window_t [`WB_LANES-1:0] window
);
	import weight_buffer_pkg::*;

	// Entry 0 holds the newest nibble and the top entry the oldest
	nibble_t [`WB_TAPS-1:0] taps [`WB_LANES];

	for (genvar l = 0; l < `WB_LANES; l++) begin : g_lane

		// The chain only moves on a write, so idle cycles keep the kernel intact
		always_ff @(posedge clk or negedge arst_n) begin
			if (!arst_n) begin
				taps[l] <= '0;
			end else if (write_en) begin
				taps[l] <= {taps[l][`WB_TAPS-2:0], weight_in[l]};
			end
		end

		// The packed chain already has the oldest nibble in the top bits
		assign window[l] = window_t'(taps[l]);

	end

endmodule

//--- rtl/write_sequencer.sv
`timescale 1ns/1ps

`include "weight_buffer_settings.svh"

module write_sequencer (
	input  logic                                      clk,
	input  logic                                      arst_n,
	input  logic                                      clear,
	input  logic                                      write_en,
	output logic [`WB_CHANNELS-1:0]                   chan_we,
	output weight_buffer_pkg::addr_t [`WB_CHANNELS-1:0] chan_addr
);
	import weight_buffer_pkg::*;

	tap_idx_t  tap_cnt;
	chan_idx_t chan_cnt;
	logic      last_tap;

	// The write that completes a kernel
	assign last_tap = write_en && (tap_cnt == tap_idx_t'(`WB_TAPS - 1));

	// Nine taps make a kernel, then the next channel takes its turn
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			tap_cnt  <= '0;
			chan_cnt <= '0;
		end else if (clear) begin
			tap_cnt  <= '0;
			chan_cnt <= '0;
		end else if (write_en) begin
			if (last_tap) begin
				tap_cnt  <= '0;
				chan_cnt <= chan_cnt + chan_idx_t'(1); // Wraps from 7 back to 0
			end else begin
				tap_cnt <= tap_cnt + tap_idx_t'(1);
			end
		end
	end

	// One-hot strobe, high for a single cycle after the ninth nibble
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			chan_we <= '0;
		end else if (clear) begin
			chan_we <= '0;
		end else begin
			chan_we <= '0;
			if (last_tap) begin
				chan_we[chan_cnt] <= 1'b1;
			end
		end
	end

	// Each channel steps its own address once its kernel has gone into the RAM
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			chan_addr <= '0;
		end else if (clear) begin
			chan_addr <= '0;
		end else begin
			for (int c = 0; c < `WB_CHANNELS; c++) begin
				if (chan_we[c]) begin
					chan_addr[c] <= chan_addr[c] + addr_t'(1);
				end
			end
		end
	end

endmodule

//--- rtl/weight_buffer_top.sv
`timescale 1ns/1ps

`include "weight_buffer_settings.svh"

module weight_buffer_top (
	input  logic                                  clk,
	input  logic                                  arst_n,
	input  logic                                  clear,
	input  logic                                  write_en,
	input  weight_buffer_pkg::nibble_t [`WB_LANES-1:0] weight_in,
	input  weight_buffer_pkg::addr_t              read_addr,
	output weight_buffer_pkg::window_t [`WB_LANES-1:0][`WB_CHANNELS-1:0] weight_win
);
	import weight_buffer_pkg::*;

	window_t [`WB_LANES-1:0]    window;
	logic [`WB_CHANNELS-1:0]    chan_we;
	addr_t [`WB_CHANNELS-1:0]   chan_addr;

	tap_shift_window u_window (
		.clk      (clk),
		.arst_n   (arst_n),
		.write_en (write_en),
		.weight_in(weight_in),
		.window   (window)
	);

	write_sequencer u_sequencer (
		.clk      (clk),
		.arst_n   (arst_n),
		.clear    (clear),
		.write_en (write_en),
		.chan_we  (chan_we),
		.chan_addr(chan_addr)
	);

	// The RAM write lands one edge after chan_we rises and sees the window before any new shift
	for (genvar l = 0; l < `WB_LANES; l++) begin : g_bank
		weight_bank u_bank (
			.clk       (clk),
			.window    (window[l]),
			.chan_we   (chan_we),
			.chan_addr (chan_addr),
			.read_addr (read_addr),
			.weight_out(weight_win[l]) // Lane l, all channels
		);
	end

endmodule

//--- tb/tb_weight_buffer.sv
`timescale 1ns/1ps

`include "weight_buffer_settings.svh"

module tb_weight_buffer;
	import weight_buffer_pkg::*;

	localparam int CASE_LIMIT  = 400; // Most tokens taken from the cases file
	localparam int IDLE_LIMIT  = 1000;
	localparam int BURST_LIMIT = 1000;

	logic                                       clk;
	logic                                       arst_n;
	logic                                       clear;
	logic                                       write_en;
	nibble_t [`WB_LANES-1:0]                    weight_in;
	addr_t                                      read_addr;
	window_t [`WB_LANES-1:0][`WB_CHANNELS-1:0] weight_win;

	// Reference model of the windows, the sequencing and the stored kernels
	window_t model_win [`WB_LANES];
	window_t model_mem [`WB_LANES][`WB_CHANNELS][`WB_DEPTH];
	bit      model_valid [`WB_CHANNELS][`WB_DEPTH];
	addr_t   model_addr [`WB_CHANNELS];
	int      model_tap;
	int      model_chan;

	window_t read_result [`WB_LANES][`WB_CHANNELS]; // Last read, used by expect lines
	string   test_name;
	int      checks;
	int      mismatches;
	int      failures;

	weight_buffer_top UUT (
		.clk       (clk),
		.arst_n    (arst_n),
		.clear     (clear),
		.write_en  (write_en),
		.weight_in (weight_in),
		.read_addr (read_addr),
		.weight_win(weight_win)
	);

	always #20 clk = ~clk;

	task automatic compare_window(input string what, input window_t expected, input window_t actual);
		checks++;
		if (actual !== expected) begin
			mismatches++;
			$display("Mismatch in %s, %s: expected %h, actual %h", test_name, what, expected, actual);
		end
	endtask

	task automatic report_failure(input string msg);
		failures++;
		$display("Error in %s: %s", test_name, msg);
	endtask

	task automatic init_model();
		for (int l = 0; l < `WB_LANES; l++) begin
			model_win[l] = '0; // The taps come out of reset as zero
		end
		for (int c = 0; c < `WB_CHANNELS; c++) begin
			model_addr[c] = '0;
			for (int a = 0; a < `WB_DEPTH; a++) begin
				model_valid[c][a] = 1'b0;
			end
		end
		model_tap  = 0;
		model_chan = 0;
	endtask

	// Every ninth nibble closes a kernel for the current channel
	task automatic model_write(input logic [31:0] word);
		for (int l = 0; l < `WB_LANES; l++) begin
			model_win[l] = window_t'({model_win[l], word[4*l +: 4]}); // Oldest nibble drops off the top
		end
		if (model_tap == `WB_TAPS - 1) begin
			for (int l = 0; l < `WB_LANES; l++) begin
				model_mem[l][model_chan][model_addr[model_chan]] = model_win[l];
			end
			model_valid[model_chan][model_addr[model_chan]] = 1'b1;
			model_addr[model_chan] = model_addr[model_chan] + addr_t'(1);
			model_chan = (model_chan + 1) % `WB_CHANNELS;
			model_tap  = 0;
		end else begin
			model_tap++;
		end
	endtask

	task automatic write_word(input logic [31:0] word);
		weight_in = word;
		write_en  = 1'b1;
		clear     = 1'b0;
		model_write(word);
		@(negedge clk);
	endtask

	task automatic random_writes(input int count);
		if (count > BURST_LIMIT) begin
			report_failure($sformatf("random burst of %0d writes is longer than allowed", count));
		end
		for (int i = 0; i < count && i < BURST_LIMIT; i++) begin
			write_word($urandom());
		end
	endtask

	task automatic idle_cycles(input int count);
		if (count > IDLE_LIMIT) begin
			report_failure($sformatf("idle stretch of %0d cycles is longer than allowed", count));
		end
		for (int i = 0; i < count && i < IDLE_LIMIT; i++) begin
			write_en = 1'b0;
			clear    = 1'b0;
			@(negedge clk);
		end
	endtask

	task automatic clear_counters();
		write_en = 1'b0;
		clear    = 1'b1;
		@(negedge clk);
		clear      = 1'b0;
		model_tap  = 0;
		model_chan = 0;
		for (int c = 0; c < `WB_CHANNELS; c++) begin
			model_addr[c] = '0;
		end
	endtask

	task automatic check_address(input addr_t addr);
		string   what;
		window_t held [`WB_LANES][`WB_CHANNELS];
		write_en = 1'b0;
		clear    = 1'b0;
		@(negedge clk); // A kernel closed by the last write reaches its RAM here
		for (int l = 0; l < `WB_LANES; l++) begin
			for (int c = 0; c < `WB_CHANNELS; c++) begin
				held[l][c] = weight_win[l][c];
			end
		end
		read_addr = addr;
		#10;
		// The registered read keeps showing the old data until the next rising edge
		for (int l = 0; l < `WB_LANES; l++) begin
			for (int c = 0; c < `WB_CHANNELS; c++) begin
				what = $sformatf("lane %0d chan %0d before addr %0d is sampled", l, c, addr);
				compare_window(what, held[l][c], weight_win[l][c]);
			end
		end
		@(negedge clk);
		for (int l = 0; l < `WB_LANES; l++) begin
			for (int c = 0; c < `WB_CHANNELS; c++) begin
				read_result[l][c] = weight_win[l][c];
				if (model_valid[c][addr]) begin
					what = $sformatf("addr %0d lane %0d chan %0d", addr, l, c);
					compare_window(what, model_mem[l][c][addr], weight_win[l][c]);
				end
			end
		end
	endtask

	task automatic expect_window(input int lane, input int chan, input window_t value);
		if (lane < 0 || lane >= `WB_LANES || chan < 0 || chan >= `WB_CHANNELS) begin
			report_failure($sformatf("expect line names lane %0d chan %0d, out of range", lane, chan));
		end else begin
			compare_window($sformatf("lane %0d chan %0d from file", lane, chan), value,
				read_result[lane][chan]);
		end
	endtask

	task automatic run_cases();
		int               fd;
		int               code;
		int               count;
		int               tokens;
		int               lane;
		int               chan;
		bit               done;
		string            cmd;
		logic [8*16-1:0]  cmd_word;
		logic [8*40-1:0]  name_word;
		logic [8*160-1:0] rest;
		logic [63:0]      value;
		fd = $fopen("tb/weight_buffer_cases.txt", "r");
		if (fd == 0) begin
			report_failure("could not open tb/weight_buffer_cases.txt");
			return;
		end
		done   = 1'b0;
		tokens = 0;
		while (!done) begin
			code = $fscanf(fd, "%s", cmd_word);
			if (code != 1) begin
				done = 1'b1; // End of file
			end else if (tokens >= CASE_LIMIT) begin
				report_failure("the cases file holds more commands than allowed");
				done = 1'b1;
			end else begin
				tokens++;
				cmd = string'(cmd_word);
				case (cmd)
					"#": begin
						code = $fgets(rest, fd);
					end
					"test": begin
						code = $fscanf(fd, "%s", name_word);
						test_name = string'(name_word);
						$display("Running %s", test_name);
					end
					"write": begin
						code = $fscanf(fd, "%h", value);
						if (code == 1) write_word(value[31:0]);
						else report_failure("write line has no data word");
					end
					"rand": begin
						code = $fscanf(fd, "%d", count);
						if (code == 1) random_writes(count);
						else report_failure("rand line has no count");
					end
					"idle": begin
						code = $fscanf(fd, "%d", count);
						if (code == 1) idle_cycles(count);
						else report_failure("idle line has no count");
					end
					"clear": begin
						clear_counters();
					end
					"check": begin
						code = $fscanf(fd, "%h", value);
						if (code == 1) check_address(addr_t'(value));
						else report_failure("check line has no address");
					end
					"expect": begin
						code = $fscanf(fd, "%d %d %h", lane, chan, value);
						if (code == 3) expect_window(lane, chan, value[35:0]);
						else report_failure("expect line needs a lane, a channel and a window");
					end
					default: begin
						report_failure($sformatf("unknown command %s in the cases file", cmd));
					end
				endcase
			end
		end
		$fclose(fd);
	endtask

	initial begin
		logic [31:0] first_draw;
		clk        = 1'b0;
		arst_n     = 1'b0;
		clear      = 1'b0;
		write_en   = 1'b0;
		weight_in  = '0;
		read_addr  = '0;
		checks     = 0;
		mismatches = 0;
		failures   = 0;
		test_name  = "reset";
		first_draw = $urandom(32'h699c_3acb);
		init_model();
		for (int i = 0; i < 2; i++) begin
			@(negedge clk);
		end
		arst_n = 1'b1;
		run_cases();
		write_en = 1'b0;
		clear    = 1'b0;
		@(negedge clk);
		if (checks == 0) begin
			report_failure("no value was compared during the run");
		end
		$display("Checks: %0d, mismatches: %0d, other errors: %0d", checks, mismatches, failures);
		if (mismatches == 0 && failures == 0) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	end

endmodule

//--- tb/weight_buffer_cases.txt
# Commands: test <name> | write <hex word, lane 0 in bits 3:0> | rand <count> | idle <cycles>
# clear | check <hex address> | expect <lane> <channel> <hex window of the last check>
test fill_addr0
write 87654321
write 98765432
write A9876543
write BA987654
write CBA98765
write DCBA9876
write EDCBA987
write FEDCBA98
write 0FEDCBA9
rand 63
check 0
expect 0 0 123456789
expect 3 0 456789ABC
expect 7 0 89ABCDEF0
test fill_addr1
rand 72
check 1
check 0
expect 0 0 123456789
test gapped_stream
write 87654321
idle 2
write 98765432
write A9876543
idle 1
write BA987654
idle 3
write CBA98765
write DCBA9876
idle 1
write EDCBA987
write FEDCBA98
idle 2
write 0FEDCBA9
rand 63
check 2
expect 0 0 123456789
expect 7 0 89ABCDEF0
test clear_restart
rand 5
clear
rand 9
check 0
test read_latency
check 1
check 2
expect 3 0 456789ABC
check 0
check 2

//--- weight_buffer_top.f
+incdir+common
common/weight_buffer_pkg.sv
weight_bank/weight_ram.sv
weight_bank/weight_bank.sv
rtl/tap_shift_window.sv
rtl/write_sequencer.sv
rtl/weight_buffer_top.sv
tb/tb_weight_buffer.sv

//--- Makefile
SIM      = verilator
FLAGS    = --binary --timing --timescale 1ns/1ps
TOP      = tb_weight_buffer
FILELIST = weight_buffer_top.f
OBJ_DIR  = obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out=$$(./$(OBJ_DIR)/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "^RESULT: PASS$$"

clean:
	rm -rf $(OBJ_DIR)
